//--- decodeStage.f
+incdir+include
hw/decode_pkg.sv
hw/decodeControl.sv
hw/regFile.sv
hw/branchEval.sv
hw/decodeStage.sv
tests/clockGen.sv
tests/decodeStage_chk.sv
tests/tb_decodeStage.sv

//--- hw/branchEval.sv
// Branch condition evaluation
`timescale 1ns/1ps
`include "decode_params.svh"

module branchEval (
   input  decode_pkg::word_t    reg1Data,
   input  decode_pkg::brCond_t  cond,
   input  logic                 isBranchClass,
   input  decode_pkg::flowCtl_t flow,
   output logic                 pcSel
);
   import decode_pkg::*;

   // Condition field encodings
   localparam brCond_t BEQZ = 2'b00;   // Rs equal to zero
   localparam brCond_t BNEZ = 2'b01;   // Rs not zero
   localparam brCond_t BLTZ = 2'b10;   // Rs below zero
   localparam brCond_t BGEZ = 2'b11;   // Rs at least zero

   logic zeroFlag;
   logic signFlag;
   logic condMet;    // Selected condition holds for Rs
   logic isBranch;   // Decoded branch or forced by control

   assign zeroFlag = (reg1Data == '0);
   assign signFlag = reg1Data[`DATA_W-1];   // Two's complement sign bit

   always_comb begin
      condMet = 1'b0;
      case (cond)
         BEQZ: condMet = zeroFlag;
         BNEZ: condMet = ~zeroFlag;
         BLTZ: condMet = signFlag;
         BGEZ: condMet = ~signFlag;
      endcase
   end

   assign isBranch = isBranchClass | flow.bFlag;

   // Halt keeps the PC where it is no matter what the branch says
   // A jump needs no condition once the branch path is active
   assign pcSel = isBranch & ~flow.halt & (condMet | flow.jFlag);

endmodule

//--- hw/decodeControl.sv
// Decode control and JAL tracking
`timescale 1ns/1ps
`include "decode_params.svh"

module decodeControl (
   input  logic                  clk,
   input  logic                  rstN,
   input  decode_pkg::opcode_t   opcode,
   input  decode_pkg::wbReq_t    wb,
   output decode_pkg::regWrite_t regWrite,
   output logic                  isBranchClass
);
   import decode_pkg::*;

   // The two jump and link opcodes
   localparam opcode_t OP_JAL  = 5'b00110;
   localparam opcode_t OP_JALR = 5'b00111;

   localparam regAddr_t LINK_ADDR = regAddr_t'(`LINK_REG);

   logic                  isJal;      // Instruction in decode links now
   logic [`JAL_DEPTH-1:0] jalTrack;   // Bit 0 sits in execute and the top bit in writeback
   logic                  wbWasJal;   // Instruction now in writeback already wrote R7

   // Opcode classification
   always_comb begin
      case (opcode)
         OP_JAL, OP_JALR: isJal = 1'b1;
         default:         isJal = 1'b0;
      endcase
   end

   // All conditional branches share the 011 prefix
   assign isBranchClass = (opcode[4:2] == 3'b011);

   // Follow each JAL down the pipe so its late writeback can be dropped
   always_ff @(posedge clk) begin
      if (!rstN) begin
         jalTrack <= '0;   // No JAL in flight after reset
      end else begin
         jalTrack <= {jalTrack[`JAL_DEPTH-2:0], isJal};
      end
   end

   assign wbWasJal = jalTrack[`JAL_DEPTH-1];

   // Write command resolution
   // A JAL in decode wins over whatever writeback presents this cycle
   always_comb begin
      if (isJal) begin
         regWrite.en      = 1'b1;
         regWrite.addr    = LINK_ADDR;   // Return address always lands in R7
         regWrite.useLink = 1'b1;
      end else begin
         regWrite.en      = wb.en & ~wbWasJal;   // R7 was written three cycles ago
         regWrite.addr    = wb.addr;
         regWrite.useLink = wb.link;
      end
   end

endmodule

//--- hw/decodeStage.sv
// Decode stage top level
`timescale 1ns/1ps

module decodeStage (
   input  logic                 clk,
   input  logic                 rstN,
   input  decode_pkg::word_t    instr,
   input  decode_pkg::word_t    imm,
   input  decode_pkg::word_t    pcNow,
   input  decode_pkg::wbReq_t   wb,
   input  decode_pkg::flowCtl_t flow,
   output decode_pkg::word_t    reg1Data,
   output decode_pkg::word_t    reg2Data,
   output logic                 pcSel
);
   import decode_pkg::*;

   regAddr_t  rs;              // First source register
   regAddr_t  rt;              // Second source register
   opcode_t   opcode;
   brCond_t   cond;            // Low opcode bits double as the branch condition
   regWrite_t regWrite;        // Resolved write into the register file
   logic      isBranchClass;

   // Instruction fields sit in fixed positions for every format
   assign opcode = instr[15:11];
   assign cond   = instr[12:11];
   assign rs     = instr[10:8];
   assign rt     = instr[7:5];

   // Classifies the opcode and decides who writes which register
   decodeControl decodeControl_i (
      .clk           (clk),
      .rstN          (rstN),
      .opcode        (opcode),
      .wb            (wb),
      .regWrite      (regWrite),
      .isBranchClass (isBranchClass)
   );

   // Register file picks its own write data from the three sources
   regFile regFile_i (
      .clk      (clk),
      .rstN     (rstN),
      .rs       (rs),
      .rt       (rt),
      .regWrite (regWrite),
      .wbData   (wb.data),
      .imm      (imm),
      .pcNow    (pcNow),
      .lbi      (wb.lbi),
      .reg1Data (reg1Data),
      .reg2Data (reg2Data)
   );

   // Rs read port drives the zero and sign tests
   branchEval branchEval_i (
      .reg1Data      (reg1Data),
      .cond          (cond),
      .isBranchClass (isBranchClass),
      .flow          (flow),
      .pcSel         (pcSel)
   );

endmodule

//--- hw/decode_pkg.sv
// Decode stage shared types
`include "decode_params.svh"

package decode_pkg;

   typedef logic [`DATA_W-1:0]     word_t;     // Data, PC or instruction word
   typedef logic [`REG_ADDR_W-1:0] regAddr_t;  // Register index
   typedef logic [4:0]             opcode_t;   // Major opcode in instr[15:11]
   typedef logic [1:0]             brCond_t;   // Branch condition in instr[12:11]

   // Write request coming back from the writeback stage
   typedef struct packed {
      word_t    data;   // Result to be written
      regAddr_t addr;   // Destination register
      logic     lbi;    // Write the immediate instead of data
      logic     link;   // Write PC plus two instead of data
      logic     en;     // Writeback wants a register write
   } wbReq_t;

   // Levels from the processor control unit
   typedef struct packed {
      logic bFlag;   // Treat this instruction as a branch
      logic jFlag;   // Take the branch whatever the condition says
      logic halt;    // Processor is halting so no redirect
   } flowCtl_t;

   // Resolved write command into the register file
   typedef struct packed {
      logic     en;
      regAddr_t addr;
      logic     useLink;   // Write data is PC plus two
   } regWrite_t;

endpackage

//--- hw/regFile.sv
// Eight entry register file
`timescale 1ns/1ps
`include "decode_params.svh"

module regFile (
   input  logic                  clk,
   input  logic                  rstN,
   input  decode_pkg::regAddr_t  rs,
   input  decode_pkg::regAddr_t  rt,
   input  decode_pkg::regWrite_t regWrite,
   input  decode_pkg::word_t     wbData,
   input  decode_pkg::word_t     imm,
   input  decode_pkg::word_t     pcNow,
   input  logic                  lbi,
   output decode_pkg::word_t     reg1Data,
   output decode_pkg::word_t     reg2Data
);
   import decode_pkg::*;

   word_t regs [`REG_CNT];   // R0 is an ordinary register here

   word_t linkData;    // Return address of the instruction in decode
   word_t writeData;   // Value that goes in on an enabled edge

   // PC plus two is the address after the current instruction
   assign linkData = pcNow + word_t'(`PC_STEP);

   // Write data selection
   // Link has priority over the load immediate
   always_comb begin
      if (regWrite.useLink) begin
         writeData = linkData;
      end else if (lbi) begin
         writeData = imm;   // Load byte immediate
      end else begin
         writeData = wbData;   // Plain writeback result
      end
   end

   // Storage
   // New contents appear at the outputs one cycle after the write
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < `REG_CNT; i++) begin
            regs[i] <= '0;   // Every register reads zero after reset
         end
      end else if (regWrite.en) begin
         regs[regWrite.addr] <= writeData;
      end
   end

   // Two read ports with no bypass from the write port
   // A same cycle write is seen only from the next cycle on
   assign reg1Data = regs[rs];   // Rs port also feeds the branch flags
   assign reg2Data = regs[rt];   // Rt port

endmodule

//--- include/decode_params.svh
// Decode stage parameters
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

`define DATA_W      16  // Data, PC and instruction word width
`define REG_CNT     8   // General registers R0 to R7
`define REG_ADDR_W  3   // Enough bits to index REG_CNT registers

// Jump and link writes its return address here
`define LINK_REG    7

`define PC_STEP     2   // Instruction size in bytes
`define JAL_DEPTH   3   // Stages between decode and writeback

`endif

//--- run.sh
#!/bin/sh
# Build the decode stage testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_decodeStage -f decodeStage.f -o simDecodeStage > build.log 2>&1
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
   cat build.log
   echo "Verilator build failed with status $buildStatus"
   exit 1
fi

./obj_dir/simDecodeStage > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "Result: FAILED" sim.log; then
   exit 1
fi
if [ $simStatus -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
   echo "Simulation ended without a verdict"
   exit 1
fi
exit 0

//--- tests/clockGen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module clockGen (
   output logic clk,
   output logic rstN
);
   localparam int HALF_PERIOD = 50;   // 100 ns clock period

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // Reset covers two rising edges and lifts shortly after the second
   initial begin
      rstN = 1'b0;
      repeat (2) @(posedge clk);
      #10;
      rstN = 1'b1;
   end

endmodule

//--- tests/decodeStage_chk.sv
// Decode stage assertions
`timescale 1ns/1ps
`include "decode_params.svh"

module decodeStage_chk (
   input logic                  clk,
   input logic                  rstN,
   input decode_pkg::opcode_t   opcode,
   input decode_pkg::wbReq_t    wb,
   input decode_pkg::flowCtl_t  flow,
   input decode_pkg::regWrite_t regWrite,
   input logic                  pcSel
);
   import decode_pkg::*;

   logic isJalOp;   // Either of the two jump and link opcodes

   assign isJalOp = (opcode == 5'b00110) || (opcode == 5'b00111);

   // A halted processor never redirects the PC
   haltBlocksPcSel: assert property (@(posedge clk) disable iff (!rstN) flow.halt |-> !pcSel)
      else $error("pcSel high while halt is high");

   // Return address always goes to the link register at once
   jalWritesLink: assert property (@(posedge clk) disable iff (!rstN)
      isJalOp |-> (regWrite.en && regWrite.useLink && regWrite.addr == regAddr_t'(`LINK_REG)))
      else $error("JAL opcode without an enabled link write to R7");

   // First active cycle writes nothing unless writeback asks
   quietAfterReset: assert property (@(posedge clk) ($rose(rstN) && !wb.en) |-> !regWrite.en)
      else $error("Register write enabled right after reset with no request");

endmodule

bind decodeStage decodeStage_chk decodeStage_chk_i (
   .clk      (clk),
   .rstN     (rstN),
   .opcode   (opcode),
   .wb       (wb),
   .flow     (flow),
   .regWrite (regWrite),
   .pcSel    (pcSel)
);

//--- tests/decode_patterns.txt
// instr imm pcNow wbData wbAddr lbi link en flow(bFlag,jFlag,halt) | reg1Data reg2Data pcSel
// All hex, one line per clock cycle, a # line names the test that follows
# reset
0140 0000 0000 0000 0 0 0 0 0 0000 0000 0
0380 0000 0000 0000 0 0 0 0 0 0000 0000 0
05c0 0000 0000 0000 0 0 0 0 0 0000 0000 0
0700 0000 0000 0000 0 0 0 0 0 0000 0000 0
# writeback
0140 0000 0000 1234 1 0 0 1 0 0000 0000 0
0120 0000 0000 5678 2 0 0 0 0 1234 1234 0
0140 0000 0000 0000 0 0 0 0 0 1234 0000 0
# writeSelect
0380 00a5 0000 ffff 3 1 0 1 0 0000 0000 0
0380 0000 0200 ffff 4 0 1 1 0 00a5 0000 0
0380 0000 0000 0000 0 0 0 0 0 00a5 0202 0
# jumpAndLink
3000 0000 0400 0000 0 0 0 0 0 0000 0000 0
0700 0000 0000 1111 5 0 0 1 0 0402 0000 0
05e0 0000 0000 2222 6 0 0 1 0 1111 0402 0
06e0 0000 0000 3333 7 0 0 1 0 2222 0402 0
0700 0000 0000 0000 0 0 0 0 0 0402 0000 0
3800 0000 0600 0000 0 0 0 0 0 0000 0000 0
0700 0000 0000 0000 0 0 0 0 0 0602 0000 0
# branchCond
0000 0000 0000 8001 2 0 0 1 0 0000 0000 0
6000 0000 0000 0000 0 0 0 0 0 0000 0000 1
6100 0000 0000 0000 0 0 0 0 0 1234 0000 0
6200 0000 0000 0000 0 0 0 0 0 8001 0000 0
6800 0000 0000 0000 0 0 0 0 0 0000 0000 0
6900 0000 0000 0000 0 0 0 0 0 1234 0000 1
6a00 0000 0000 0000 0 0 0 0 0 8001 0000 1
7000 0000 0000 0000 0 0 0 0 0 0000 0000 0
7100 0000 0000 0000 0 0 0 0 0 1234 0000 0
7200 0000 0000 0000 0 0 0 0 0 8001 0000 1
7800 0000 0000 0000 0 0 0 0 0 0000 0000 1
7900 0000 0000 0000 0 0 0 0 0 1234 0000 1
7a00 0000 0000 0000 0 0 0 0 0 8001 0000 0
# flowControl
0000 0000 0000 0000 0 0 0 0 4 0000 0000 1
0100 0000 0000 0000 0 0 0 0 4 1234 0000 0
0900 0000 0000 0000 0 0 0 0 4 1234 0000 1
0900 0000 0000 0000 0 0 0 0 0 1234 0000 0
6100 0000 0000 0000 0 0 0 0 2 1234 0000 1
0100 0000 0000 0000 0 0 0 0 2 1234 0000 0
6000 0000 0000 0000 0 0 0 0 1 0000 0000 0
6000 0000 0000 0000 0 0 0 0 3 0000 0000 0
0000 0000 0000 0000 0 0 0 0 5 0000 0000 0

//--- tests/tb_decodeStage.sv
// Decode stage testbench
`timescale 1ns/1ps

module tb_decodeStage;
   import decode_pkg::*;

   localparam int RESET_TIMEOUT = 20;    // Cycles allowed for reset to lift
   localparam int MAX_CYCLES    = 500;   // Upper bound on vectors in the file

   logic     clk;
   logic     rstN;
   word_t    instr;
   word_t    imm;
   word_t    pcNow;
   wbReq_t   wb;
   flowCtl_t flow;
   word_t    reg1Data;
   word_t    reg2Data;
   logic     pcSel;

   int    fd;            // Pattern file handle
   int    waitCycles;
   int    vectorCount;   // Vectors applied so far
   string line;
   string testName;      // Set by the latest # line

   clockGen clockGen_i (
      .clk  (clk),
      .rstN (rstN)
   );

   decodeStage decodeStage_i (
      .clk      (clk),
      .rstN     (rstN),
      .instr    (instr),
      .imm      (imm),
      .pcNow    (pcNow),
      .wb       (wb),
      .flow     (flow),
      .reg1Data (reg1Data),
      .reg2Data (reg2Data),
      .pcSel    (pcSel)
   );

   // Print why the run stopped and end it
   task automatic abortRun(input string reason);
      $display("%s", reason);
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic checkEq(input string name, input word_t expected, input word_t actual);
      if (expected !== actual) begin
         abortRun($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
      end
   endtask

   // One pattern line is one clock cycle of stimulus and expected outputs
   task automatic applyVector(input string text);
      word_t      fInstr;
      word_t      fImm;
      word_t      fPc;
      word_t      fData;
      word_t      fExp1;
      word_t      fExp2;
      logic [3:0] fAddr;
      logic [3:0] fLbi;
      logic [3:0] fLink;
      logic [3:0] fEn;
      logic [3:0] fFlow;   // bFlag, jFlag, halt from the top bit down
      logic [3:0] fSel;
      int         count;
      count = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h", fInstr, fImm, fPc,
                      fData, fAddr, fLbi, fLink, fEn, fFlow, fExp1, fExp2, fSel);
      if (count != 12) begin
         abortRun($sformatf("Pattern line in test %s has %0d fields instead of 12",
                            testName, count));
      end else begin
         #10;   // Inputs change shortly after the rising edge
         instr     = fInstr;
         imm       = fImm;
         pcNow     = fPc;
         wb.data   = fData;
         wb.addr   = fAddr[2:0];
         wb.lbi    = fLbi[0];
         wb.link   = fLink[0];
         wb.en     = fEn[0];
         flow.bFlag = fFlow[2];
         flow.jFlag = fFlow[1];
         flow.halt  = fFlow[0];
         #50;   // Sample 40 ns ahead of the next edge
         checkEq({testName, " reg1Data"}, fExp1, reg1Data);
         checkEq({testName, " reg2Data"}, fExp2, reg2Data);
         checkEq({testName, " pcSel"}, {15'b0, fSel[0]}, {15'b0, pcSel});
         @(posedge clk);
         vectorCount++;
      end
   endtask

   initial begin
      instr       = '0;
      imm         = '0;
      pcNow       = '0;
      wb          = '0;
      flow        = '0;
      testName    = "unnamed";
      vectorCount = 0;
      waitCycles  = 0;
      fd = $fopen("tests/decode_patterns.txt", "r");
      if (fd == 0) abortRun("Could not open the pattern file tests/decode_patterns.txt");
      while (rstN !== 1'b1) begin
         @(posedge clk);
         waitCycles++;
         if (waitCycles > RESET_TIMEOUT) abortRun("Reset was never released");
      end
      // Walk the file until it ends or runs past the cycle limit
      while (!$feof(fd)) begin
         if (vectorCount > MAX_CYCLES) abortRun("Pattern file did not end within the cycle limit");
         line = "";
         if ($fgets(line, fd) != 0) begin
            if (line.len() >= 2 && line[0] == "#") begin
               void'($sscanf(line, "# %s", testName));   // New test starts here
            end else if (line.len() >= 2 && line[0] != "/") begin
               applyVector(line);
            end
         end
      end
      $fclose(fd);
      if (vectorCount > 0) begin
         $display("Result: PASSED");
         $finish;
      end else begin
         abortRun("The pattern file held no vectors");
      end
   end

endmodule
